// File: src/pwm_consts.svh
// PWM generator sizing constants shared by the package and the RTL blocks
`ifndef PWM_CONSTS_SVH
`define PWM_CONSTS_SVH

// Width of the period counter, the period register and every threshold
`define PWM_COUNTER_WIDTH 16

// Number of complementary output channels
`define PWM_N_CHANNELS 4

// Width of the dead-time register and of the per-channel dead-time counters
`define PWM_DEAD_TIME_WIDTH 8

// Period value loaded into the register bank by reset
`define PWM_RESET_PERIOD 100

`endif

// File: src/pwm_pkg.sv
// PWM generator types for counter mode, write address map, thresholds and control word
`include "pwm_consts.svh"

package pwm_pkg;

    // Counting mode of the period counter
    // Up-down mode gives centre-aligned PWM with a period of twice the programmed value
    typedef enum logic {
        count_up      = 1'b0,
        count_up_down = 1'b1
    } counter_mode_e;

    // Write address map of the register bank
    // Channel i owns the on threshold at 4+2i and the off threshold at 5+2i
    typedef enum logic [3:0] {
        addr_control   = 4'd0,
        addr_period    = 4'd1,
        addr_dead_time = 4'd2,
        addr_polarity  = 4'd3,
        addr_ch0_on    = 4'd4,
        addr_ch0_off   = 4'd5,
        addr_ch1_on    = 4'd6,
        addr_ch1_off   = 4'd7,
        addr_ch2_on    = 4'd8,
        addr_ch2_off   = 4'd9,
        addr_ch3_on    = 4'd10,
        addr_ch3_off   = 4'd11
    } reg_address_e;

    // Switching thresholds of one channel
    typedef struct packed {
        logic [`PWM_COUNTER_WIDTH-1:0] on_threshold;
        logic [`PWM_COUNTER_WIDTH-1:0] off_threshold;
    } channel_thresholds_t;

    // Control word, with mode in bit 1 and run in bit 0
    typedef struct packed {
        counter_mode_e mode;
        logic          run;
    } pwm_control_t;

endpackage

// File: src/pwm_config_regs.sv
// PWM configuration register bank decoding write strobes into control, timing and thresholds
`timescale 1ns/1ps
`include "pwm_consts.svh"

module pwm_config_regs (
    input  logic                                                  clock,
    input  logic                                                  reset,
    input  logic                                                  write_enable,
    input  pwm_pkg::reg_address_e                                 write_address,
    input  logic [15:0]                                           write_data,
    output pwm_pkg::pwm_control_t                                 control,
    output logic [`PWM_COUNTER_WIDTH-1:0]                         period,
    output logic [`PWM_DEAD_TIME_WIDTH-1:0]                       dead_time,
    output logic [`PWM_N_CHANNELS-1:0]                            polarity,
    output pwm_pkg::channel_thresholds_t [`PWM_N_CHANNELS-1:0]    thresholds
);

    // Threshold addresses are counted from the first on threshold
    logic [3:0] threshold_offset;
    // Channel selected by a threshold write
    logic [$clog2(`PWM_N_CHANNELS)-1:0] threshold_channel;
    // High when the address falls inside the threshold block
    logic threshold_hit;
    // Bit 0 of the offset picks the off threshold of the pair
    logic threshold_is_off;

    // The threshold block starts right after the four fixed registers
    always_comb begin
        threshold_offset  = 4'(write_address) - 4'(pwm_pkg::addr_ch0_on);
        threshold_hit     = (write_address >= pwm_pkg::addr_ch0_on) &&
                            (threshold_offset < 4'(2 * `PWM_N_CHANNELS));
        threshold_channel = threshold_offset[$clog2(`PWM_N_CHANNELS):1];
        threshold_is_off  = threshold_offset[0];
    end

    // Every register is updated on the write edge and shows its new value the cycle after
    always_ff @(posedge clock) begin
        if (!reset) begin
            // Stopped, up-counting, default period and no dead time
            control.run  <= 1'b0;
            control.mode <= pwm_pkg::count_up;
            period       <= `PWM_COUNTER_WIDTH'(`PWM_RESET_PERIOD);
            dead_time    <= '0;
            polarity     <= '0;
            thresholds   <= '0;
        end else if (write_enable) begin
            case (write_address)
                pwm_pkg::addr_control: begin
                    control <= pwm_pkg::pwm_control_t'(write_data[1:0]);
                end
                pwm_pkg::addr_period: begin
                    period <= write_data[`PWM_COUNTER_WIDTH-1:0];
                end
                pwm_pkg::addr_dead_time: begin
                    dead_time <= write_data[`PWM_DEAD_TIME_WIDTH-1:0];
                end
                pwm_pkg::addr_polarity: begin
                    polarity <= write_data[`PWM_N_CHANNELS-1:0];
                end
                default: begin
                    // Remaining mapped addresses are the threshold pairs
                    // Anything past the last channel is dropped here
                    if (threshold_hit) begin
                        if (threshold_is_off) begin
                            thresholds[threshold_channel].off_threshold <=
                                write_data[`PWM_COUNTER_WIDTH-1:0];
                        end else begin
                            thresholds[threshold_channel].on_threshold <=
                                write_data[`PWM_COUNTER_WIDTH-1:0];
                        end
                    end
                end
            endcase
        end
    end

endmodule

// File: src/pwm_period_counter.sv
// PWM period counter running up or up-down to the programmed period with a period start pulse
`timescale 1ns/1ps
`include "pwm_consts.svh"

module pwm_period_counter (
    input  logic                           clock,
    input  logic                           reset,
    input  pwm_pkg::pwm_control_t          control,
    input  logic [`PWM_COUNTER_WIDTH-1:0]  period,
    output logic [`PWM_COUNTER_WIDTH-1:0]  counter_value,
    output logic                           counter_stopped,
    output logic                           period_start
);

    // Period in use for the current leg, taken from the register at wrap or turn-around
    logic [`PWM_COUNTER_WIDTH-1:0] active_period;
    // Direction state for centre-aligned mode, high while counting down
    logic counting_down;

    always_ff @(posedge clock) begin
        if (!reset) begin
            counter_value   <= '0;
            counting_down   <= 1'b0;
            counter_stopped <= 1'b1;
            period_start    <= 1'b0;
            active_period   <= `PWM_COUNTER_WIDTH'(`PWM_RESET_PERIOD);
        end else if (!control.run) begin
            // Stopping parks the counter at zero heading up
            counter_value   <= '0;
            counting_down   <= 1'b0;
            counter_stopped <= 1'b1;
            period_start    <= 1'b0;
        end else if (counter_stopped) begin
            // First running cycle sits at zero and opens the first period
            counter_stopped <= 1'b0;
            period_start    <= 1'b1;
            active_period   <= period;
        end else begin
            period_start <= 1'b0;
            case (control.mode)
                pwm_pkg::count_up: begin
                    // Sawtooth from 0 to the period, so one period is period+1 cycles
                    counting_down <= 1'b0;
                    if (counter_value >= active_period) begin
                        counter_value <= '0;
                        period_start  <= 1'b1;
                        active_period <= period;
                    end else begin
                        counter_value <= counter_value + 1'b1;
                    end
                end
                default: begin
                    // Triangle from 0 up to the period and back down to 1
                    if (!counting_down) begin
                        if (counter_value >= active_period) begin
                            active_period <= period;
                            if (counter_value > `PWM_COUNTER_WIDTH'(1)) begin
                                counting_down <= 1'b1;
                                counter_value <= counter_value - 1'b1;
                            end else begin
                                // A period of one has no down leg at all
                                counter_value <= '0;
                                period_start  <= 1'b1;
                            end
                        end else begin
                            counter_value <= counter_value + 1'b1;
                        end
                    end else if (counter_value <= `PWM_COUNTER_WIDTH'(1)) begin
                        // Bottom of the triangle starts the next period
                        counter_value <= '0;
                        counting_down <= 1'b0;
                        period_start  <= 1'b1;
                        active_period <= period;
                    end else begin
                        counter_value <= counter_value - 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

// File: src/compare_unit.sv
// PWM compare unit with shadow thresholds and registered per-channel counter comparisons
`timescale 1ns/1ps
`include "pwm_consts.svh"

module compare_unit (
    input  logic                                               clock,
    input  logic                                               reset,
    input  logic [`PWM_COUNTER_WIDTH-1:0]                      counter_value,
    input  logic                                               counter_stopped,
    input  pwm_pkg::channel_thresholds_t [`PWM_N_CHANNELS-1:0] thresholds,
    input  logic                                               reload,
    output logic [`PWM_N_CHANNELS-1:0]                         match_high,
    output logic [`PWM_N_CHANNELS-1:0]                         match_low
);

    // Thresholds that the running period compares against
    pwm_pkg::channel_thresholds_t [`PWM_N_CHANNELS-1:0] shadow;
    // Thresholds seen by the comparators this cycle
    pwm_pkg::channel_thresholds_t [`PWM_N_CHANNELS-1:0] active;
    // Shadows follow the register bank while stopped and at each period start
    logic load;

    assign load = counter_stopped | reload;

    // On a load cycle the comparators already see the new values
    // That way the counter value 0 of a new period belongs to the new thresholds
    always_comb begin
        active = load ? thresholds : shadow;
    end

    // Writes in the middle of a period wait here until the next reload
    always_ff @(posedge clock) begin
        if (load) begin
            shadow <= thresholds;
        end
    end

    // Both flags are registered one cycle behind the counter
    always_ff @(posedge clock) begin
        if (!reset) begin
            match_high <= '0;
            match_low  <= '0;
        end else begin
            for (int i = 0; i < `PWM_N_CHANNELS; i++) begin
                match_low[i]  <= counter_value <  active[i].off_threshold;
                match_high[i] <= counter_value >= active[i].on_threshold;
            end
        end
    end

endmodule

// File: src/pwm_output_stage.sv
// PWM output stage forming raw levels with polarity and inserting dead time on complementary pairs
`timescale 1ns/1ps
`include "pwm_consts.svh"

module pwm_output_stage (
    input  logic                             clock,
    input  logic                             reset,
    input  logic [`PWM_N_CHANNELS-1:0]       match_high,
    input  logic [`PWM_N_CHANNELS-1:0]       match_low,
    input  logic                             counter_stopped,
    input  logic [`PWM_N_CHANNELS-1:0]       polarity,
    input  logic [`PWM_DEAD_TIME_WIDTH-1:0]  dead_time,
    output logic [`PWM_N_CHANNELS-1:0]       pwm_high,
    output logic [`PWM_N_CHANNELS-1:0]       pwm_low
);

    // Level the channel will take on the next edge
    logic [`PWM_N_CHANNELS-1:0] raw_next;
    // Registered raw level, which is also the previous value raw_next is compared to
    logic [`PWM_N_CHANNELS-1:0] raw_level;
    // High once a channel has served its dead time
    logic [`PWM_N_CHANNELS-1:0] dead_done;
    // Per-channel dead-time down-counters
    logic [`PWM_DEAD_TIME_WIDTH-1:0] dead_count [`PWM_N_CHANNELS];

    // Inside the on/off window the channel is active, polarity flips the sense
    always_comb begin
        raw_next = (match_high & match_low) ^ polarity;
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            raw_level <= '0;
            for (int i = 0; i < `PWM_N_CHANNELS; i++) begin
                dead_count[i] <= '0;
            end
        end else begin
            raw_level <= raw_next;
            for (int i = 0; i < `PWM_N_CHANNELS; i++) begin
                if (counter_stopped) begin
                    // Keep a full dead time armed so the first switch-on after a start waits too
                    dead_count[i] <= dead_time;
                end else if (raw_next[i] != raw_level[i]) begin
                    // An edge loads the counter in the same edge that moves the raw level
                    dead_count[i] <= dead_time;
                end else if (dead_count[i] != '0) begin
                    dead_count[i] <= dead_count[i] - 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `PWM_N_CHANNELS; i++) begin
            dead_done[i] = dead_count[i] == '0;
        end
    end

    // The side switching off follows raw at once, the side switching on waits for dead_done
    // While stopped both transistors of every leg are held off
    assign pwm_high = raw_level & dead_done & {`PWM_N_CHANNELS{~counter_stopped}};
    assign pwm_low  = ~raw_level & dead_done & {`PWM_N_CHANNELS{~counter_stopped}};

endmodule

// File: src/pwm_generator.sv
// Four-channel PWM generator top level connecting register bank, counter, comparators and outputs
`timescale 1ns/1ps
`include "pwm_consts.svh"

module pwm_generator (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        write_enable,
    input  pwm_pkg::reg_address_e       write_address,
    input  logic [15:0]                 write_data,
    output logic [`PWM_N_CHANNELS-1:0]  pwm_high,
    output logic [`PWM_N_CHANNELS-1:0]  pwm_low,
    output logic                        period_start
);

    // Register bank outputs
    pwm_pkg::pwm_control_t                              control;
    logic [`PWM_COUNTER_WIDTH-1:0]                      period;
    logic [`PWM_DEAD_TIME_WIDTH-1:0]                    dead_time;
    logic [`PWM_N_CHANNELS-1:0]                         polarity;
    pwm_pkg::channel_thresholds_t [`PWM_N_CHANNELS-1:0] thresholds;

    // Counter state shared by the compare unit and the output stage
    logic [`PWM_COUNTER_WIDTH-1:0] counter_value;
    logic                          counter_stopped;

    // Per-channel comparator flags
    logic [`PWM_N_CHANNELS-1:0] match_high;
    logic [`PWM_N_CHANNELS-1:0] match_low;

    pwm_config_regs pwm_config_regs_inst (
        .clock         (clock),
        .reset         (reset),
        .write_enable  (write_enable),
        .write_address (write_address),
        .write_data    (write_data),
        .control       (control),
        .period        (period),
        .dead_time     (dead_time),
        .polarity      (polarity),
        .thresholds    (thresholds)
    );

    pwm_period_counter pwm_period_counter_inst (
        .clock           (clock),
        .reset           (reset),
        .control         (control),
        .period          (period),
        .counter_value   (counter_value),
        .counter_stopped (counter_stopped),
        .period_start    (period_start)
    );

    // The period start pulse doubles as the shadow reload strobe
    compare_unit compare_unit_inst (
        .clock           (clock),
        .reset           (reset),
        .counter_value   (counter_value),
        .counter_stopped (counter_stopped),
        .thresholds      (thresholds),
        .reload          (period_start),
        .match_high      (match_high),
        .match_low       (match_low)
    );

    pwm_output_stage pwm_output_stage_inst (
        .clock           (clock),
        .reset           (reset),
        .match_high      (match_high),
        .match_low       (match_low),
        .counter_stopped (counter_stopped),
        .polarity        (polarity),
        .dead_time       (dead_time),
        .pwm_high        (pwm_high),
        .pwm_low         (pwm_low)
    );

endmodule

// File: bench/pwm_generator_tb.sv
// Testbench for the four-channel PWM generator covering period, duty, reload, dead time and stop
`timescale 1ns/1ps
`include "pwm_consts.svh"

module pwm_generator_tb;

    localparam int n_ch = `PWM_N_CHANNELS;
    // Cycles a single wait may take before the run is declared hung
    localparam int wait_limit = 4000;

    logic                  clock;
    logic                  reset;
    logic                  write_enable;
    pwm_pkg::reg_address_e write_address;
    logic [15:0]           write_data;
    logic [n_ch-1:0]       pwm_high;
    logic [n_ch-1:0]       pwm_low;
    logic                  period_start;

    // Expected configuration kept alongside every register write
    int period_model;
    int dead_model;
    int on_model [n_ch];
    int off_model [n_ch];

    // Monitor state is updated on the falling edge and read by the stimulus on the rising edge
    int              cycle;
    int              start_count;
    int              last_start_cycle;
    int              last_interval;
    int              high_run [n_ch];
    int              low_run [n_ch];
    int              both_low_run [n_ch];
    int              high_pulses [n_ch];
    int              low_pulses [n_ch];
    int              last_high_width [n_ch];
    int              last_low_width [n_ch];
    logic [n_ch-1:0] prev_high;
    logic [n_ch-1:0] prev_low;

    int          error_count;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    string       test_name;

    pwm_generator pwm_generator_inst (
        .clock         (clock),
        .reset         (reset),
        .write_enable  (write_enable),
        .write_address (write_address),
        .write_data    (write_data),
        .pwm_high      (pwm_high),
        .pwm_low       (pwm_low),
        .period_start  (period_start)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #4 clock = ~clock;
        end
    end

    function automatic void report_error(string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        error_count++;
        test_errors++;
    endfunction

    // The two transistors of one leg never conduct at the same time
    no_shoot_through: assert property (@(posedge clock) disable iff (!reset)
        (pwm_high & pwm_low) == '0)
        else report_error($sformatf("pwm_high %b overlaps pwm_low %b", pwm_high, pwm_low));

    // Pulse widths, idle gaps and period start spacing are all counted in clock cycles
    always @(negedge clock) begin
        cycle++;
        if (reset) begin
            if (period_start) begin
                last_interval    = cycle - last_start_cycle;
                last_start_cycle = cycle;
                start_count++;
            end
            for (int i = 0; i < n_ch; i++) begin
                // A side that switches on must have seen the full dead time with both sides off
                if ((pwm_high[i] && !prev_high[i]) || (pwm_low[i] && !prev_low[i])) begin
                    assert (both_low_run[i] >= dead_model)
                        else report_error($sformatf("channel %0d on after %0d idle cycles, need %0d",
                                                    i, both_low_run[i], dead_model));
                end
                if (pwm_high[i]) begin
                    high_run[i]++;
                end else if (prev_high[i]) begin
                    last_high_width[i] = high_run[i];
                    high_pulses[i]++;
                    high_run[i] = 0;
                end
                if (pwm_low[i]) begin
                    low_run[i]++;
                end else if (prev_low[i]) begin
                    last_low_width[i] = low_run[i];
                    low_pulses[i]++;
                    low_run[i] = 0;
                end
                both_low_run[i] = (!pwm_high[i] && !pwm_low[i]) ? both_low_run[i] + 1 : 0;
            end
            prev_high = pwm_high;
            prev_low  = pwm_low;
        end
    end

    task automatic begin_test(string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, test_errors);
        end
    endtask

    task automatic finish_run();
        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    task automatic report_timeout(string what);
        $display("Timeout: no %s seen within %0d cycles in test %s", what, wait_limit, test_name);
        error_count++;
        test_errors++;
        end_test();
        finish_run();
    endtask

    // One write strobe is driven just after the rising edge and accepted on the next one
    task automatic write_reg(pwm_pkg::reg_address_e address, int data);
        @(posedge clock);
        #1;
        write_enable  = 1'b1;
        write_address = address;
        write_data    = 16'(data);
        @(posedge clock);
        #1;
        write_enable  = 1'b0;
    endtask

    task automatic stop_counter();
        write_reg(pwm_pkg::addr_control, 0);
    endtask

    // Control word has mode in bit 1 and run in bit 0
    task automatic run_counter(pwm_pkg::counter_mode_e mode);
        write_reg(pwm_pkg::addr_control, (int'(mode) << 1) | 1);
    endtask

    // Random windows with at least 8 cycles on and the off threshold kept below the period
    task automatic program_thresholds();
        for (int i = 0; i < n_ch; i++) begin
            on_model[i]  = 3 + int'($urandom % (period_model / 4));
            off_model[i] = on_model[i] + 8 + int'($urandom % (period_model / 2));
            write_reg(pwm_pkg::reg_address_e'(4 + 2 * i), on_model[i]);
            write_reg(pwm_pkg::reg_address_e'(5 + 2 * i), off_model[i]);
        end
    endtask

    task automatic wait_starts(int count);
        int target;
        int waited;
        target = start_count + count;
        waited = 0;
        while (start_count < target) begin
            @(posedge clock);
            waited++;
            if (waited > wait_limit) begin
                report_timeout("period start pulse");
            end
        end
    endtask

    task automatic wait_pulses(int ch, int high_target, int low_target);
        int waited;
        waited = 0;
        while (high_pulses[ch] < high_target || low_pulses[ch] < low_target) begin
            @(posedge clock);
            waited++;
            if (waited > wait_limit) begin
                report_timeout($sformatf("complete pulse on channel %0d", ch));
            end
        end
    endtask

    // The window is off-on cycles and the rest of the period belongs to the other side
    // Each side loses the dead time at its switch-on
    task automatic check_all_channels(bit inverted);
        int window;
        int rest;
        int exp_high;
        int exp_low;
        for (int i = 0; i < n_ch; i++) begin
            // The first pulse after a start may be cut short and is skipped
            wait_pulses(i, high_pulses[i] + 2, low_pulses[i] + 2);
            window   = off_model[i] - on_model[i];
            rest     = period_model + 1 - window;
            exp_high = (inverted ? rest : window) - dead_model;
            exp_low  = (inverted ? window : rest) - dead_model;
            assert (last_high_width[i] == exp_high)
                else report_error($sformatf("channel %0d pwm_high width %0d, expected %0d",
                                            i, last_high_width[i], exp_high));
            assert (last_low_width[i] == exp_low)
                else report_error($sformatf("channel %0d pwm_low width %0d, expected %0d",
                                            i, last_low_width[i], exp_low));
        end
    endtask

    // With no dead time the low side mirrors the high side on every cycle of a period
    task automatic check_complement();
        repeat (period_model + 1) begin
            @(negedge clock);
            assert (pwm_low == ~pwm_high)
                else report_error($sformatf("pwm_low %b is not the inverse of pwm_high %b",
                                            pwm_low, pwm_high));
        end
    endtask

    initial begin
        int waited;
        int high_target;
        int old_width;
        int new_width;
        int starts_before;
        void'($urandom(82));
        reset         = 1'b0;
        write_enable  = 1'b0;
        write_address = pwm_pkg::addr_control;
        write_data    = '0;
        prev_high     = '0;
        prev_low      = '0;
        dead_model    = 0;
        period_model  = `PWM_RESET_PERIOD;
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b1;

        // Nothing may move while run is still clear
        begin_test("reset_state");
        repeat (20) begin
            @(negedge clock);
            assert (pwm_high == '0 && pwm_low == '0 && period_start == 1'b0)
                else report_error("outputs active while run is clear");
        end
        end_test();

        begin_test("period_length");
        period_model = 20 + int'($urandom % 80);
        write_reg(pwm_pkg::addr_period, period_model);
        run_counter(pwm_pkg::count_up);
        wait_starts(3);
        assert (last_interval == period_model + 1)
            else report_error($sformatf("up period %0d cycles, expected %0d",
                                        last_interval, period_model + 1));
        stop_counter();
        period_model = 20 + int'($urandom % 80);
        write_reg(pwm_pkg::addr_period, period_model);
        run_counter(pwm_pkg::count_up_down);
        wait_starts(3);
        assert (last_interval == 2 * period_model)
            else report_error($sformatf("up-down period %0d cycles, expected %0d",
                                        last_interval, 2 * period_model));
        end_test();

        begin_test("duty_cycle");
        stop_counter();
        period_model = 48 + int'($urandom % 48);
        write_reg(pwm_pkg::addr_period, period_model);
        write_reg(pwm_pkg::addr_dead_time, 0);
        write_reg(pwm_pkg::addr_polarity, 0);
        program_thresholds();
        run_counter(pwm_pkg::count_up);
        check_all_channels(1'b0);
        check_complement();
        // Inverted polarity swaps the high and low times
        stop_counter();
        write_reg(pwm_pkg::addr_polarity, 'hf);
        run_counter(pwm_pkg::count_up);
        check_all_channels(1'b1);
        check_complement();
        end_test();

        begin_test("shadow_reload");
        stop_counter();
        write_reg(pwm_pkg::addr_polarity, 0);
        run_counter(pwm_pkg::count_up);
        wait_pulses(0, high_pulses[0] + 2, low_pulses[0] + 2);
        wait_starts(1);
        // The off threshold drops by 3 early in a period
        high_target = high_pulses[0] + 1;
        old_width   = off_model[0] - on_model[0];
        new_width   = old_width - 3;
        off_model[0] = off_model[0] - 3;
        write_reg(pwm_pkg::addr_ch0_off, off_model[0]);
        wait_pulses(0, high_target, 0);
        assert (last_high_width[0] == old_width)
            else report_error($sformatf("current period width %0d, expected %0d",
                                        last_high_width[0], old_width));
        wait_pulses(0, high_target + 1, 0);
        assert (last_high_width[0] == new_width)
            else report_error($sformatf("next period width %0d, expected %0d",
                                        last_high_width[0], new_width));
        end_test();

        begin_test("dead_time");
        stop_counter();
        period_model = 48 + int'($urandom % 48);
        dead_model   = 1 + int'($urandom % 6);
        write_reg(pwm_pkg::addr_period, period_model);
        write_reg(pwm_pkg::addr_dead_time, dead_model);
        program_thresholds();
        run_counter(pwm_pkg::count_up);
        check_all_channels(1'b0);
        check_all_channels(1'b0);
        end_test();

        begin_test("stop");
        stop_counter();
        waited = 0;
        do begin
            @(negedge clock);
            waited++;
        end while ((pwm_high != '0 || pwm_low != '0) && waited < 3);
        assert (pwm_high == '0 && pwm_low == '0)
            else report_error("outputs still active 3 cycles after run was cleared");
        starts_before = start_count;
        repeat (3 * (period_model + 1)) begin
            @(negedge clock);
            assert (pwm_high == '0 && pwm_low == '0 && period_start == 1'b0)
                else report_error("activity on the outputs while stopped");
        end
        assert (start_count == starts_before)
            else report_error("period start pulses counted while stopped");
        end_test();

        finish_run();
    end

endmodule

// File: src.f
+incdir+src
src/pwm_pkg.sv
src/pwm_config_regs.sv
src/pwm_period_counter.sv
src/compare_unit.sv
src/pwm_output_stage.sv
src/pwm_generator.sv
bench/pwm_generator_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the PWM generator testbench with Verilator, then scan the log for failure

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module pwm_generator_tb -o pwm_generator_sim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/pwm_generator_sim > "$LOG" 2>&1 \
    || echo "** FAIL **" >> "$LOG"

cat "$LOG"

grep -q -F "** FAIL **" "$LOG" \
    && { echo "Simulation failed"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }
